// File: design/xif_pkg.sv
/*
  Shared widths, opcode encodings and the completion record of the
  coprocessor offload subsystem. Modules refer to it by scoped names.
*/
`default_nettype none

package xif_pkg;

  // instruction id width, sized for up to eight ids in flight
  parameter int unsigned IdWidth = 3;
  // operand and result width
  parameter int unsigned DataWidth = 32;
  // scratch memory address width, 16 words
  parameter int unsigned AddrWidth = 4;

  // ALU opcodes, taken from the two-bit op field of an issue
  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_SUB = 2'b01,
    ALU_XOR = 2'b10
  } alu_op_e;

  // load/store opcodes, same two-bit op field
  typedef enum logic [1:0] {
    LSU_LOAD  = 2'b00,
    LSU_STORE = 2'b01
  } lsu_op_e;

  // which execution unit takes an instruction
  // a trap is executed by no unit and commits killed
  typedef enum logic [1:0] {
    KIND_ALU  = 2'b00,
    KIND_LSU  = 2'b01,
    KIND_TRAP = 2'b10
  } issue_kind_e;

  // completion record on the shared completion bus
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic                 wb;
  } done_t;

endpackage

`default_nettype wire

// File: design/xif_done_if.sv
/*
  Completion handshake between one execution unit and the completion arbiter.
  The unit holds req and rec stable until the cycle in which gnt is high.
*/
`timescale 1ns/1ps
`default_nettype none

interface xif_done_if;

  // completion pending from the unit
  logic            req;
  // arbiter grant, transfer happens in this cycle
  logic            gnt;
  // id, result and writeback flag of the completing instruction
  xif_pkg::done_t  rec;

  modport unit (
    output req,
    output rec,
    input  gnt
  );

  modport arbiter (
    input  req,
    input  rec,
    output gnt
  );

endinterface

`default_nettype wire

// File: design/xif_issue_commit_buffer.sv
/*
  Issue-commit buffer. Hands out ids at issue, tracks completion per entry and
  commits the oldest entry in issue order, at most one per cycle. A flush
  drops every uncommitted entry and rewinds the issue pointer.
*/
`timescale 1ns/1ps
`default_nettype none

module xif_issue_commit_buffer #(
  parameter int unsigned BufferDepth = 8
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         flush_i,
  // issue side
  input  wire logic                         issue_valid_i,
  input  wire xif_pkg::issue_kind_e         issue_kind_i,
  output logic [xif_pkg::IdWidth-1:0]       issue_id_o,
  output logic                              issue_ready_o,
  // arbitrated completions
  input  wire logic                         done_valid_i,
  input  wire xif_pkg::done_t               done_i,
  // commit strobe
  output logic                              commit_valid_o,
  output logic                              commit_kill_o,
  output logic [xif_pkg::IdWidth-1:0]       commit_id_o
);

  localparam int unsigned PtrWidth = $clog2(BufferDepth);

  // per-entry flags, indexed by the low id bits
  logic [BufferDepth-1:0] valid_d, valid_q;
  logic [BufferDepth-1:0] finished_d, finished_q;
  logic [BufferDepth-1:0] trap_d, trap_q;

  logic [PtrWidth-1:0] issue_ptr_d, issue_ptr_q;
  logic [PtrWidth-1:0] commit_ptr_d, commit_ptr_q;
  logic [PtrWidth-1:0] done_ptr;

  logic issue_fire;
  logic issue_trap;

  // full when the slot at the issue pointer has not retired yet
  assign issue_ready_o = ~valid_q[issue_ptr_q];
  assign issue_fire    = issue_valid_i & issue_ready_o;
  assign issue_id_o    = xif_pkg::IdWidth'(issue_ptr_q);

  // any kind that no unit executes is treated as a trap
  assign issue_trap = (issue_kind_i != xif_pkg::KIND_ALU) &&
                      (issue_kind_i != xif_pkg::KIND_LSU);

  assign done_ptr = PtrWidth'(done_i.id);

  // oldest entry retires once finished, a trap retires at once
  assign commit_valid_o = valid_q[commit_ptr_q] &
                          (finished_q[commit_ptr_q] | trap_q[commit_ptr_q]);
  assign commit_kill_o  = commit_valid_o & trap_q[commit_ptr_q];
  assign commit_id_o    = xif_pkg::IdWidth'(commit_ptr_q);

  always_comb begin
    valid_d      = valid_q;
    finished_d   = finished_q;
    trap_d       = trap_q;
    issue_ptr_d  = issue_ptr_q;
    commit_ptr_d = commit_ptr_q;

    // a commit in the flush cycle still counts, the host has seen it
    if (commit_valid_o) begin
      valid_d[commit_ptr_q] = 1'b0;
      commit_ptr_d          = commit_ptr_q + 1'b1;
    end

    if (flush_i) begin
      // everything still valid is uncommitted
      valid_d     = '0;
      issue_ptr_d = commit_ptr_d;
    end else begin
      if (done_valid_i) begin
        finished_d[done_ptr] = 1'b1;
      end
      if (issue_fire) begin
        valid_d[issue_ptr_q]    = 1'b1;
        finished_d[issue_ptr_q] = 1'b0;
        trap_d[issue_ptr_q]     = issue_trap;
        issue_ptr_d             = issue_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= '0;
      finished_q   <= '0;
      trap_q       <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
    end else begin
      valid_q      <= valid_d;
      finished_q   <= finished_d;
      trap_q       <= trap_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
    end
  end

endmodule

`default_nettype wire

// File: design/xif_alu_unit.sv
/*
  Pipelined ALU execution unit. The result is computed at issue and shifted
  through AluLatency stages; the head stage requests the completion bus.
*/
`timescale 1ns/1ps
`default_nettype none

module xif_alu_unit #(
  parameter int unsigned AluLatency = 2
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           flush_i,
  input  wire logic                           start_i,
  input  wire xif_pkg::alu_op_e               op_i,
  input  wire logic [xif_pkg::IdWidth-1:0]    id_i,
  input  wire logic [xif_pkg::DataWidth-1:0]  a_i,
  input  wire logic [xif_pkg::DataWidth-1:0]  b_i,
  xif_done_if.unit                            done
);

  localparam int unsigned Last = AluLatency - 1;

  logic [AluLatency-1:0]        vld_q;
  logic [xif_pkg::IdWidth-1:0]   id_q  [AluLatency];
  logic [xif_pkg::DataWidth-1:0] res_q [AluLatency];

  // one-entry skid for a start that arrives while stalled
  logic                          skid_vld_q;
  logic [xif_pkg::IdWidth-1:0]   skid_id_q;
  logic [xif_pkg::DataWidth-1:0] skid_res_q;

  logic [xif_pkg::DataWidth-1:0] new_res;
  logic                          start;
  logic                          stall;

  always_comb begin
    case (op_i)
      xif_pkg::ALU_ADD: new_res = a_i + b_i;
      xif_pkg::ALU_SUB: new_res = a_i - b_i;
      default:          new_res = a_i ^ b_i;
    endcase
  end

  // issues in the flush cycle are discarded, same as in the buffer
  assign start = start_i & ~flush_i;
  // whole pipe holds while the head waits for its grant
  assign stall = vld_q[Last] & ~done.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q      <= '0;
      skid_vld_q <= 1'b0;
    end else if (flush_i) begin
      vld_q      <= '0;
      skid_vld_q <= 1'b0;
    end else if (stall) begin
      if (start) begin
        skid_vld_q <= 1'b1;
      end
    end else begin
      for (int k = Last; k > 0; k--) begin
        vld_q[k] <= vld_q[k-1];
      end
      vld_q[0]   <= skid_vld_q | start;
      // skid drains into stage 0, a new start refills it
      skid_vld_q <= skid_vld_q & start;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      for (int k = Last; k > 0; k--) begin
        id_q[k]  <= id_q[k-1];
        res_q[k] <= res_q[k-1];
      end
      id_q[0]  <= skid_vld_q ? skid_id_q : id_i;
      res_q[0] <= skid_vld_q ? skid_res_q : new_res;
    end
    if (start && (stall || skid_vld_q)) begin
      skid_id_q  <= id_i;
      skid_res_q <= new_res;
    end
  end

  assign done.req = vld_q[Last];
  assign done.rec = xif_pkg::done_t'{id: id_q[Last], data: res_q[Last], wb: 1'b1};

endmodule

`default_nettype wire

// File: design/xif_lsu_unit.sv
/*
  Load/store unit with a 16-word scratch memory. Loads complete with the read
  data; a store completes without writeback and lands in memory only when the
  buffer commits its id. At most one store is outstanding.
*/
`timescale 1ns/1ps
`default_nettype none

module xif_lsu_unit (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           flush_i,
  input  wire logic                           start_i,
  input  wire xif_pkg::lsu_op_e               op_i,
  input  wire logic [xif_pkg::IdWidth-1:0]    id_i,
  input  wire logic [xif_pkg::AddrWidth-1:0]  addr_i,
  input  wire logic [xif_pkg::DataWidth-1:0]  wdata_i,
  input  wire logic                           commit_valid_i,
  input  wire logic [xif_pkg::IdWidth-1:0]    commit_id_i,
  output logic                                store_pending_o,
  xif_done_if.unit                            done
);

  localparam int unsigned Words = 2 ** xif_pkg::AddrWidth;

  logic [xif_pkg::DataWidth-1:0] mem_q [Words];

  // completion request and its record
  logic           req_q;
  xif_pkg::done_t rec_q;

  // the one store waiting for its commit
  logic                          st_pend_q;
  logic [xif_pkg::AddrWidth-1:0] st_addr_q;
  logic [xif_pkg::DataWidth-1:0] st_data_q;
  logic [xif_pkg::IdWidth-1:0]   st_id_q;

  logic start;
  logic is_store;
  logic st_commit;

  assign start    = start_i & ~flush_i;
  assign is_store = (op_i == xif_pkg::LSU_STORE);

  // commit strobe naming the pending store, honoured even in a flush cycle
  assign st_commit = st_pend_q & commit_valid_i & (commit_id_i == st_id_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q     <= 1'b0;
      st_pend_q <= 1'b0;
    end else begin
      if (flush_i) begin
        req_q <= 1'b0;
      end else if (start) begin
        req_q <= 1'b1;
      end else if (done.gnt) begin
        req_q <= 1'b0;
      end
      if (flush_i || st_commit) begin
        st_pend_q <= 1'b0;
      end else if (start && is_store) begin
        st_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      // a load samples memory at issue, a store reports no data
      rec_q.id   <= id_i;
      rec_q.data <= is_store ? '0 : mem_q[addr_i];
      rec_q.wb   <= ~is_store;
    end
    if (start && is_store) begin
      st_addr_q <= addr_i;
      st_data_q <= wdata_i;
      st_id_q   <= id_i;
    end
    if (st_commit) begin
      mem_q[st_addr_q] <= st_data_q;
    end
  end

  assign done.req        = req_q;
  assign done.rec        = rec_q;
  // blocks further issue until the store has retired or been flushed
  assign store_pending_o = st_pend_q;

endmodule

`default_nettype wire

// File: design/xif_completion_arbiter.sv
/*
  Round-robin arbiter of the ALU and load/store completions onto the single
  completion bus. Grant is combinational; priority flips after a contest.
*/
`timescale 1ns/1ps
`default_nettype none

module xif_completion_arbiter (
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  xif_done_if.arbiter alu,
  xif_done_if.arbiter lsu,
  output logic           done_valid_o,
  output xif_pkg::done_t done_o
);

  // low gives the ALU priority, high the load/store unit
  logic prio_lsu_q;
  logic contest;

  assign contest = alu.req & lsu.req;

  // a lone request wins at once
  assign alu.gnt = alu.req & (~lsu.req | ~prio_lsu_q);
  assign lsu.gnt = lsu.req & (~alu.req | prio_lsu_q);

  assign done_valid_o = alu.req | lsu.req;
  assign done_o       = alu.gnt ? alu.rec : lsu.rec;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_lsu_q <= 1'b0;
    end else if (contest) begin
      // loser of this contest wins the next one
      prio_lsu_q <= ~prio_lsu_q;
    end
  end

endmodule

`default_nettype wire

// File: design/xif_offload_top.sv
/*
  Top level of the coprocessor offload subsystem. Decodes the raw issue fields,
  steers each instruction to its unit and connects the buffer, the ALU, the
  load/store unit and the completion arbiter.
*/
`timescale 1ns/1ps
`default_nettype none

module xif_offload_top #(
  parameter int unsigned AluLatency  = 2,
  parameter int unsigned BufferDepth = 8
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           flush_i,
  input  wire logic                           issue_valid_i,
  input  wire logic [1:0]                     issue_kind_i,
  input  wire logic [1:0]                     issue_op_i,
  input  wire logic [xif_pkg::DataWidth-1:0]  issue_a_i,
  input  wire logic [xif_pkg::DataWidth-1:0]  issue_b_i,
  output logic                                issue_ready_o,
  output logic [xif_pkg::IdWidth-1:0]         issue_id_o,
  output logic                                commit_valid_o,
  output logic [xif_pkg::IdWidth-1:0]         commit_id_o,
  output logic                                commit_kill_o,
  output logic                                result_valid_o,
  output logic [xif_pkg::IdWidth-1:0]         result_id_o,
  output logic [xif_pkg::DataWidth-1:0]       result_data_o
);

  xif_pkg::issue_kind_e kind;
  xif_pkg::done_t       done;
  logic                 done_valid;
  logic                 buf_ready;
  logic                 store_pending;
  logic                 issue_fire;

  xif_done_if alu_done ();
  xif_done_if lsu_done ();

  assign kind = xif_pkg::issue_kind_e'(issue_kind_i);

  // the host only strobes while ready, the gate keeps the units in step anyway
  assign issue_fire    = issue_valid_i & issue_ready_o;
  assign issue_ready_o = buf_ready & ~store_pending;

  xif_issue_commit_buffer #(
    .BufferDepth (BufferDepth)
  ) i_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .issue_valid_i  (issue_fire),
    .issue_kind_i   (kind),
    .issue_id_o     (issue_id_o),
    .issue_ready_o  (buf_ready),
    .done_valid_i   (done_valid),
    .done_i         (done),
    .commit_valid_o (commit_valid_o),
    .commit_kill_o  (commit_kill_o),
    .commit_id_o    (commit_id_o)
  );

  xif_alu_unit #(
    .AluLatency (AluLatency)
  ) i_alu (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .start_i (issue_fire & (kind == xif_pkg::KIND_ALU)),
    .op_i    (xif_pkg::alu_op_e'(issue_op_i)),
    .id_i    (issue_id_o),
    .a_i     (issue_a_i),
    .b_i     (issue_b_i),
    .done    (alu_done)
  );

  // operand a carries the scratch address, operand b the store data
  xif_lsu_unit i_lsu (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .start_i         (issue_fire & (kind == xif_pkg::KIND_LSU)),
    .op_i            (xif_pkg::lsu_op_e'(issue_op_i)),
    .id_i            (issue_id_o),
    .addr_i          (issue_a_i[xif_pkg::AddrWidth-1:0]),
    .wdata_i         (issue_b_i),
    .commit_valid_i  (commit_valid_o),
    .commit_id_i     (commit_id_o),
    .store_pending_o (store_pending),
    .done            (lsu_done)
  );

  xif_completion_arbiter i_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .alu          (alu_done),
    .lsu          (lsu_done),
    .done_valid_o (done_valid),
    .done_o       (done)
  );

  // only completions with writeback reach the host result port
  assign result_valid_o = done_valid & done.wb;
  assign result_id_o    = done.id;
  assign result_data_o  = done.data;

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
/*
  Testbench clock and reset source. Drives a free-running clock and holds
  the active-low reset for a fixed number of rising edges after time zero.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 10,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release on a rising edge, as the other stimulus
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_xif_offload.sv
/*
  Directed testbench of the offload subsystem. Issues ALU, load/store and trap
  instructions, predicts commits and results from a small reference model and
  checks them from a monitor on the falling clock edge.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_xif_offload;

  localparam int unsigned Timeout  = 200;
  localparam logic [15:0] LfsrSeed = 16'd45544;

  logic clk;
  logic rst_n;
  logic flush;
  logic issue_valid;
  logic [1:0] issue_kind;
  logic [1:0] issue_op;
  logic [xif_pkg::DataWidth-1:0] issue_a;
  logic [xif_pkg::DataWidth-1:0] issue_b;
  logic issue_ready;
  logic [xif_pkg::IdWidth-1:0] issue_id;
  logic commit_valid;
  logic [xif_pkg::IdWidth-1:0] commit_id;
  logic commit_kill;
  logic result_valid;
  logic [xif_pkg::IdWidth-1:0] result_id;
  logic [xif_pkg::DataWidth-1:0] result_data;

  // reference model
  logic [xif_pkg::IdWidth-1:0]   exp_commit_id [$];
  logic                          exp_commit_kill [$];
  xif_pkg::done_t                alu_res_q [$];
  xif_pkg::done_t                lsu_res_q [$];
  logic [xif_pkg::DataWidth-1:0] mem_model [16];
  logic                          pend_vld;
  logic [xif_pkg::IdWidth-1:0]   pend_id;
  logic [xif_pkg::AddrWidth-1:0] pend_addr;
  logic [xif_pkg::DataWidth-1:0] pend_data;
  logic [xif_pkg::IdWidth-1:0]   next_id;
  logic [xif_pkg::IdWidth-1:0]   commit_ptr;
  logic [xif_pkg::AddrWidth-1:0] store_addr;

  logic [15:0] lfsr;
  int unsigned checks;
  int unsigned errors;
  int unsigned timeouts;

  tb_clock_gen #(
    .PeriodNs    (10),
    .ResetCycles (8)
  ) i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  xif_offload_top i_xif_offload_top (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .flush_i        (flush),
    .issue_valid_i  (issue_valid),
    .issue_kind_i   (issue_kind),
    .issue_op_i     (issue_op),
    .issue_a_i      (issue_a),
    .issue_b_i      (issue_b),
    .issue_ready_o  (issue_ready),
    .issue_id_o     (issue_id),
    .commit_valid_o (commit_valid),
    .commit_id_o    (commit_id),
    .commit_kill_o  (commit_kill),
    .result_valid_o (result_valid),
    .result_id_o    (result_id),
    .result_data_o  (result_data)
  );

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] alu_ref(input logic [1:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (xif_pkg::alu_op_e'(op))
      xif_pkg::ALU_ADD: return a + b;
      xif_pkg::ALU_SUB: return a - b;
      default:          return a ^ b;
    endcase
  endfunction

  task automatic finish_run();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t: %s expected %b got %b", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_id(input logic [xif_pkg::IdWidth-1:0] exp,
                          input logic [xif_pkg::IdWidth-1:0] got);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t: issue_id_o expected %0d got %0d", $time, exp, got);
      errors++;
    end
  endtask

  task automatic check_commit(input logic [xif_pkg::IdWidth-1:0] exp_id, input logic exp_kill,
                              input logic [xif_pkg::IdWidth-1:0] got_id, input logic got_kill);
    checks++;
    if (got_id !== exp_id) begin
      $display("** Error at %0t: commit_id_o expected %0d got %0d", $time, exp_id, got_id);
      errors++;
    end
    if (got_kill !== exp_kill) begin
      $display("** Error at %0t: commit_kill_o expected %b got %b", $time, exp_kill, got_kill);
      errors++;
    end
  endtask

  task automatic check_result(input xif_pkg::done_t exp_rec, input xif_pkg::done_t got_rec);
    checks++;
    if (got_rec.id !== exp_rec.id) begin
      $display("** Error at %0t: result_id_o expected %0d got %0d", $time,
               exp_rec.id, got_rec.id);
      errors++;
    end
    if (got_rec.data !== exp_rec.data) begin
      $display("** Error at %0t: result_data_o expected %h got %h", $time,
               exp_rec.data, got_rec.data);
      errors++;
    end
  endtask

  task automatic observe_commit();
    logic [xif_pkg::IdWidth-1:0] id;
    if (exp_commit_id.size() == 0) begin
      $display("commit of id %0d at %0t with nothing outstanding", commit_id, $time);
      errors++;
    end else begin
      id = exp_commit_id.pop_front();
      check_commit(id, exp_commit_kill.pop_front(), commit_id, commit_kill);
      commit_ptr = id + 1'b1;
      // a store lands in memory on its own commit only
      if (pend_vld && pend_id == id) begin
        mem_model[pend_addr] = pend_data;
        pend_vld = 1'b0;
      end
    end
  endtask

  task automatic observe_result();
    xif_pkg::done_t got;
    got.id   = result_id;
    got.data = result_data;
    got.wb   = 1'b1;
    // the two units may finish in either order
    if (lsu_res_q.size() != 0 && lsu_res_q[0].id == result_id) begin
      check_result(lsu_res_q.pop_front(), got);
    end else if (alu_res_q.size() != 0) begin
      check_result(alu_res_q.pop_front(), got);
    end else begin
      $display("result for id %0d at %0t that no instruction expects", result_id, $time);
      errors++;
    end
  endtask

  // outputs depend on registered state only, stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (commit_valid) begin
        observe_commit();
      end
      if (result_valid) begin
        observe_result();
      end
    end
  end

  task automatic wait_ready();
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while (!issue_ready) begin
      cycles++;
      if (cycles > Timeout) begin
        $display("timed out at %0t waiting for issue_ready_o", $time);
        timeouts++;
        finish_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_drained();
    int unsigned cycles;
    cycles = 0;
    @(posedge clk);
    while (exp_commit_id.size() != 0 || alu_res_q.size() != 0 || lsu_res_q.size() != 0) begin
      cycles++;
      if (cycles > Timeout) begin
        $display("timed out at %0t waiting for outstanding commits and results", $time);
        timeouts++;
        finish_run();
      end
      @(posedge clk);
    end
  endtask

  // one issue strobe, the DUT samples it at the next rising edge
  task automatic drive_issue(input xif_pkg::issue_kind_e kind, input logic [1:0] op,
                             input logic [31:0] a, input logic [31:0] b);
    xif_pkg::done_t rec;
    @(posedge clk);
    issue_valid <= 1'b1;
    issue_kind  <= kind;
    issue_op    <= op;
    issue_a     <= a;
    issue_b     <= b;
    @(negedge clk);
    if (!issue_ready) begin
      $display("issue at %0t was strobed while the DUT was not ready", $time);
      errors++;
    end
    check_id(next_id, issue_id);
    rec.id = next_id;
    rec.wb = 1'b1;
    exp_commit_id.push_back(next_id);
    exp_commit_kill.push_back(kind == xif_pkg::KIND_TRAP);
    if (kind == xif_pkg::KIND_ALU) begin
      rec.data = alu_ref(op, a, b);
      alu_res_q.push_back(rec);
    end else if (kind == xif_pkg::KIND_LSU) begin
      if (xif_pkg::lsu_op_e'(op) == xif_pkg::LSU_STORE) begin
        pend_vld  = 1'b1;
        pend_id   = next_id;
        pend_addr = a[xif_pkg::AddrWidth-1:0];
        pend_data = b;
      end else begin
        // store before it has already committed
        rec.data = mem_model[a[xif_pkg::AddrWidth-1:0]];
        lsu_res_q.push_back(rec);
      end
    end
    next_id = next_id + 1'b1;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    issue_valid <= 1'b0;
    flush       <= 1'b0;
  endtask

  task automatic drive_random_alu(input logic [1:0] op);
    logic [31:0] a;
    logic [31:0] b;
    take_bits(32, a);
    take_bits(32, b);
    drive_issue(xif_pkg::KIND_ALU, op, a, b);
  endtask

  task automatic drive_flush();
    @(posedge clk);
    issue_valid <= 1'b0;
    flush       <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    // flush edge, the model forgets whatever has not committed
    exp_commit_id.delete();
    exp_commit_kill.delete();
    alu_res_q.delete();
    lsu_res_q.delete();
    pend_vld = 1'b0;
    next_id  = commit_ptr;
  endtask

  task automatic test_alu_ops();
    wait_ready();
    drive_random_alu(xif_pkg::ALU_ADD);
    drive_idle();
    wait_ready();
    drive_random_alu(xif_pkg::ALU_SUB);
    drive_idle();
    wait_ready();
    drive_random_alu(xif_pkg::ALU_XOR);
    drive_idle();
    wait_drained();
  endtask

  task automatic test_alu_burst();
    logic [31:0] r;
    wait_ready();
    // several in flight at once, ids must come back in order
    repeat (6) begin
      take_bits(2, r);
      drive_random_alu(2'(r % 3));
    end
    drive_idle();
    wait_drained();
  endtask

  task automatic test_store_load();
    logic [31:0] r;
    logic [31:0] d;
    take_bits(4, r);
    take_bits(32, d);
    store_addr = r[xif_pkg::AddrWidth-1:0];
    wait_ready();
    drive_issue(xif_pkg::KIND_LSU, xif_pkg::LSU_STORE, 32'(store_addr), d);
    drive_idle();
    wait_drained();
    wait_ready();
    drive_issue(xif_pkg::KIND_LSU, xif_pkg::LSU_LOAD, 32'(store_addr), '0);
    drive_idle();
    wait_drained();
  endtask

  task automatic test_trap();
    wait_ready();
    drive_random_alu(xif_pkg::ALU_ADD);
    drive_issue(xif_pkg::KIND_TRAP, 2'b00, '0, '0);
    drive_random_alu(xif_pkg::ALU_XOR);
    drive_idle();
    wait_drained();
  endtask

  task automatic test_collision();
    // ALU latency 2 and load latency 1 meet in the same cycle
    repeat (2) begin
      wait_ready();
      drive_random_alu(xif_pkg::ALU_SUB);
      drive_issue(xif_pkg::KIND_LSU, xif_pkg::LSU_LOAD, 32'(store_addr), '0);
      drive_idle();
      wait_drained();
    end
  endtask

  task automatic test_flush();
    logic [31:0] d;
    wait_ready();
    drive_random_alu(xif_pkg::ALU_ADD);
    drive_flush();
    // quiet window, the monitor flags anything that shows up
    repeat (6) @(negedge clk);
    check_id(next_id, issue_id);
    take_bits(32, d);
    wait_ready();
    drive_issue(xif_pkg::KIND_LSU, xif_pkg::LSU_STORE, 32'(store_addr), d);
    drive_flush();
    repeat (6) @(negedge clk);
    check_id(next_id, issue_id);
    // old data still there
    wait_ready();
    drive_issue(xif_pkg::KIND_LSU, xif_pkg::LSU_LOAD, 32'(store_addr), '0);
    drive_idle();
    wait_drained();
  endtask

  initial begin
    int unsigned cycles;
    flush       = 1'b0;
    issue_valid = 1'b0;
    issue_kind  = '0;
    issue_op    = '0;
    issue_a     = '0;
    issue_b     = '0;
    lfsr        = LfsrSeed;
    pend_vld    = 1'b0;
    next_id     = '0;
    commit_ptr  = '0;
    store_addr  = '0;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    cycles      = 0;
    while (rst_n !== 1'b1) begin
      cycles++;
      if (cycles > Timeout) begin
        $display("timed out at %0t waiting for reset release", $time);
        timeouts++;
        finish_run();
      end
      @(posedge clk);
    end
    @(negedge clk);
    check_flag("issue_ready_o", 1'b1, issue_ready);
    check_flag("commit_valid_o", 1'b0, commit_valid);
    check_flag("result_valid_o", 1'b0, result_valid);
    check_id('0, issue_id);
    test_alu_ops();
    test_alu_burst();
    test_store_load();
    test_trap();
    test_collision();
    test_flush();
    finish_run();
  end

endmodule

`default_nettype wire

// File: sources.f
design/xif_pkg.sv
design/xif_done_if.sv
design/xif_issue_commit_buffer.sv
design/xif_alu_unit.sv
design/xif_lsu_unit.sv
design/xif_completion_arbiter.sv
design/xif_offload_top.sv
verification/tb_clock_gen.sv
verification/tb_xif_offload.sv

// File: Bender.yml
package:
  name: xif_offload

sources:
  - design/xif_pkg.sv
  - design/xif_done_if.sv
  - design/xif_issue_commit_buffer.sv
  - design/xif_alu_unit.sv
  - design/xif_lsu_unit.sv
  - design/xif_completion_arbiter.sv
  - design/xif_offload_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_xif_offload.sv
